// File: src/icache_pkg.sv
package icache_pkg;

    // address and data widths
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 8;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int BEAT_W     = 2;

    // one cache line, word 0 in the low bits
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // flat word for the memory port, fields for the arrays
    typedef union packed {
        logic [ADDR_W-1:0] word;
        addr_fields_t      f;
    } addr_t;

    // read burst types on the memory port
    localparam logic [2:0] RD_TYPE_WORD = 3'd2;
    localparam logic [2:0] RD_TYPE_LINE = 3'd4;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        MISS   = 2'd2,
        REFILL = 2'd3
    } ctrl_state_t;

endpackage

// File: src/icache_ifs.sv
`timescale 1ns/1ps

// tag lookup and tag update between controller and tag store
interface tag_lookup_if #(
    parameter int NUM_WAYS = 2
);
    localparam int WAY_W = $clog2(NUM_WAYS);

    logic                           lookup_en;
    logic [icache_pkg::INDEX_W-1:0] lookup_index;
    logic [icache_pkg::TAG_W-1:0]   lookup_tag;
    logic                           fill_en;
    logic [WAY_W-1:0]               fill_way;
    logic                           hit;
    logic [WAY_W-1:0]               hit_way;

    modport ctrl (
        output lookup_en, lookup_index, lookup_tag, fill_en, fill_way,
        input  hit, hit_way
    );

    modport store (
        input  lookup_en, lookup_index, lookup_tag, fill_en, fill_way,
        output hit, hit_way
    );
endinterface

// refill line assembly between controller and fill buffer
interface line_fill_if;
    logic              fill_start;
    icache_pkg::line_t line;
    logic              line_done;

    modport ctrl (
        output fill_start,
        input  line, line_done
    );

    modport fill (
        input  fill_start,
        output line, line_done
    );
endinterface

// File: src/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store #(
    parameter int NUM_WAYS = 2
) (
    input logic         clk,
    input logic         resetn,
    tag_lookup_if.store tl
);

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int SETS  = 2 ** icache_pkg::INDEX_W;

    logic [icache_pkg::TAG_W-1:0] tag_mem [NUM_WAYS][SETS];
    logic [SETS-1:0]              valid_mem [NUM_WAYS];

    // per-way copies taken at acceptance
    logic [icache_pkg::TAG_W-1:0] tag_copy [NUM_WAYS];
    logic [NUM_WAYS-1:0]          valid_copy;
    logic [icache_pkg::TAG_W-1:0] held_tag;

    logic [NUM_WAYS-1:0] hit_vec;
    logic [WAY_W-1:0]    hit_enc;

    // index and tag on the lookup lines also address the refill write
    always_ff @(posedge clk) begin
        if (tl.fill_en) begin
            tag_mem[tl.fill_way][tl.lookup_index] <= tl.lookup_tag;
        end
        if (tl.lookup_en) begin
            held_tag <= tl.lookup_tag;
            for (int w = 0; w < NUM_WAYS; w++) begin
                tag_copy[w] <= tag_mem[w][tl.lookup_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_mem[w] <= '0;
            end
            valid_copy <= '0;
        end else begin
            if (tl.fill_en) begin
                valid_mem[tl.fill_way][tl.lookup_index] <= 1'b1;
            end
            if (tl.lookup_en) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    valid_copy[w] <= valid_mem[w][tl.lookup_index];
                end
            end
        end
    end

    // compare copies against the held tag
    always_comb begin
        hit_enc = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_copy[w] && (tag_copy[w] == held_tag);
            if (hit_vec[w]) begin
                hit_enc = WAY_W'(w);
            end
        end
    end

    assign tl.hit     = |hit_vec;
    assign tl.hit_way = hit_enc;

    // refills only happen on a miss, so a tag never lives in two ways of a set
    a_one_way_hits: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(hit_vec));

endmodule

// File: src/icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store #(
    parameter int NUM_WAYS = 2
) (
    input  logic                            clk,
    input  logic [icache_pkg::INDEX_W-1:0]  rd_index,
    input  logic [$clog2(NUM_WAYS)-1:0]     hit_way,
    input  logic [icache_pkg::BEAT_W-1:0]   word_off,
    input  logic                            wr_en,
    input  logic [$clog2(NUM_WAYS)-1:0]     wr_way,
    input  icache_pkg::line_t               wr_line,
    output logic [icache_pkg::WORD_W-1:0]   sel_word
);

    localparam int SETS = 2 ** icache_pkg::INDEX_W;

    icache_pkg::line_t way_line [NUM_WAYS];
    icache_pkg::line_t sel_line;

    // one line array per way, registered read
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_pkg::line_t mem [SETS];
        icache_pkg::line_t rd_line;

        always_ff @(posedge clk) begin
            if (wr_en && (wr_way == w)) begin
                mem[rd_index] <= wr_line;
            end
            rd_line <= mem[rd_index];
        end

        assign way_line[w] = rd_line;
    end

    // hitting way, then the requested word
    assign sel_line = way_line[hit_way];
    assign sel_word = sel_line[word_off*icache_pkg::WORD_W +: icache_pkg::WORD_W];

endmodule

// File: src/icache_line_fill.sv
`timescale 1ns/1ps

module icache_line_fill (
    input logic                          clk,
    input logic                          resetn,
    input logic                          ret_valid,
    input logic                          ret_last,
    input logic [icache_pkg::WORD_W-1:0] ret_data,
    line_fill_if.fill                    lf
);

    logic [icache_pkg::BEAT_W-1:0] beat;
    logic                          active;
    logic                          done_q;
    icache_pkg::line_t             line_buf;
    logic                          take_beat;

    // uncached single beats arrive while inactive and are ignored
    assign take_beat = active && ret_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            beat   <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (lf.fill_start) begin
                active <= 1'b1;
                beat   <= '0;
            end else if (take_beat) begin
                beat <= beat + 1'b1;
                if (ret_last) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // each beat lands in its word slot
    always_ff @(posedge clk) begin
        if (take_beat) begin
            line_buf[beat*icache_pkg::WORD_W +: icache_pkg::WORD_W] <= ret_data;
        end
    end

    assign lf.line      = line_buf;
    assign lf.line_done = done_q;

    // burst length agrees with the line size
    a_last_on_fourth: assert property (@(posedge clk) disable iff (!resetn)
        take_beat |-> (ret_last == (beat == icache_pkg::BEAT_W'(icache_pkg::LINE_WORDS - 1))));

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int NUM_WAYS = 2
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  logic                           uncached,
    input  logic [icache_pkg::ADDR_W-1:0]  addr,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic [icache_pkg::WORD_W-1:0]  rdata,
    output logic                           rd_req,
    output logic [2:0]                     rd_type,
    output logic [icache_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  logic [icache_pkg::WORD_W-1:0]  ret_data,
    input  logic [icache_pkg::WORD_W-1:0]  sel_word,
    output logic [icache_pkg::INDEX_W-1:0] rd_index,
    output logic [icache_pkg::BEAT_W-1:0]  word_off,
    output logic                           wr_line_en,
    output logic [$clog2(NUM_WAYS)-1:0]    wr_way,
    tag_lookup_if.ctrl                     tl,
    line_fill_if.ctrl                      lf
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    icache_pkg::ctrl_state_t state;
    icache_pkg::addr_t       in_addr;
    icache_pkg::addr_t       req;
    logic                    req_uncached;
    logic [WAY_W-1:0]        victim;

    logic                           accept;
    logic                           lookup_hit;
    logic                           refill_done;
    logic                           word_done;
    logic [icache_pkg::INDEX_W-1:0] cur_index;
    logic [1:0]                     outstanding;

    assign in_addr = addr;

    // a cached hit frees the lookup stage for the next request
    assign lookup_hit = (state == icache_pkg::LOOKUP) && tl.hit && !req_uncached;
    assign addr_ok    = (state == icache_pkg::IDLE) || lookup_hit;
    assign accept     = valid && addr_ok;

    assign refill_done = (state == icache_pkg::REFILL) && !req_uncached && lf.line_done;
    assign word_done   = (state == icache_pkg::REFILL) && req_uncached && ret_valid && ret_last;

    // arrays see the incoming index on acceptance, the held one otherwise
    assign cur_index       = accept ? in_addr.f.index : req.f.index;
    assign rd_index        = cur_index;
    assign word_off        = req.f.offset[icache_pkg::OFFSET_W-1:2];
    assign tl.lookup_en    = accept;
    assign tl.lookup_index = cur_index;
    assign tl.lookup_tag   = accept ? in_addr.f.tag : req.f.tag;

    // victim way gets both tag and line
    assign tl.fill_en  = refill_done;
    assign tl.fill_way = victim;
    assign wr_line_en  = refill_done;
    assign wr_way      = victim;

    assign rd_req        = (state == icache_pkg::MISS);
    assign rd_type       = req_uncached ? icache_pkg::RD_TYPE_WORD : icache_pkg::RD_TYPE_LINE;
    assign rd_addr       = req_uncached ? req.word
                                        : {req.f.tag, req.f.index, {icache_pkg::OFFSET_W{1'b0}}};
    assign lf.fill_start = rd_req && rd_rdy && !req_uncached;

    assign data_ok = lookup_hit || refill_done || word_done;

    always_comb begin
        if (req_uncached) begin
            rdata = ret_data;
        end else if (state == icache_pkg::LOOKUP) begin
            rdata = sel_word;
        end else begin
            rdata = lf.line[word_off*icache_pkg::WORD_W +: icache_pkg::WORD_W];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= in_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= icache_pkg::IDLE;
            req_uncached <= 1'b0;
            victim       <= '0;
            outstanding  <= '0;
        end else begin
            if (accept) begin
                req_uncached <= uncached;
            end
            if (refill_done) begin
                victim <= (victim == WAY_W'(NUM_WAYS - 1)) ? '0 : victim + 1'b1;
            end
            // answers still owed to the fetch side
            outstanding <= outstanding + 2'(accept) - 2'(data_ok);
            case (state)
                icache_pkg::IDLE: begin
                    if (accept) begin
                        state <= icache_pkg::LOOKUP;
                    end
                end
                icache_pkg::LOOKUP: begin
                    if (!lookup_hit) begin
                        state <= icache_pkg::MISS;
                    end else if (!accept) begin
                        state <= icache_pkg::IDLE;
                    end
                end
                icache_pkg::MISS: begin
                    if (rd_rdy) begin
                        state <= icache_pkg::REFILL;
                    end
                end
                default: begin
                    if (refill_done || word_done) begin
                        state <= icache_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    a_rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr) && $stable(rd_type));

    // every answer belongs to an accepted request
    a_data_ok_source: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> (outstanding != 2'd0));

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int NUM_WAYS = 2
) (
    input  logic                          clk,
    input  logic                          resetn,
    // fetch side
    input  logic                          valid,
    input  logic                          uncached,
    input  logic [icache_pkg::ADDR_W-1:0] addr,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [icache_pkg::WORD_W-1:0] rdata,
    // memory side
    output logic                          rd_req,
    output logic [2:0]                    rd_type,
    output logic [icache_pkg::ADDR_W-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  logic [icache_pkg::WORD_W-1:0] ret_data
);

    logic [icache_pkg::INDEX_W-1:0] rd_index;
    logic [icache_pkg::BEAT_W-1:0]  word_off;
    logic                           wr_line_en;
    logic [$clog2(NUM_WAYS)-1:0]    wr_way;
    logic [icache_pkg::WORD_W-1:0]  sel_word;

    tag_lookup_if #(.NUM_WAYS(NUM_WAYS)) tl_if ();
    line_fill_if lf_if ();

    icache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .uncached   (uncached),
        .addr       (addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_type    (rd_type),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .sel_word   (sel_word),
        .rd_index   (rd_index),
        .word_off   (word_off),
        .wr_line_en (wr_line_en),
        .wr_way     (wr_way),
        .tl         (tl_if.ctrl),
        .lf         (lf_if.ctrl)
    );

    icache_tag_store #(.NUM_WAYS(NUM_WAYS)) u_tag_store (
        .clk    (clk),
        .resetn (resetn),
        .tl     (tl_if.store)
    );

    // read way follows the tag hit, write way the victim
    icache_data_store #(.NUM_WAYS(NUM_WAYS)) u_data_store (
        .clk      (clk),
        .rd_index (rd_index),
        .hit_way  (tl_if.hit_way),
        .word_off (word_off),
        .wr_en    (wr_line_en),
        .wr_way   (wr_way),
        .wr_line  (lf_if.line),
        .sel_word (sel_word)
    );

    icache_line_fill u_line_fill (
        .clk       (clk),
        .resetn    (resetn),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .lf        (lf_if.fill)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// File: tb/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] PATTERN = 32'h0
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        rd_req,
    input  logic [2:0]  rd_type,
    input  logic [31:0] rd_addr,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output logic [31:0] ret_data
);

    int          seed;
    int          beats;
    logic [31:0] base;

    initial begin
        seed      = 91378;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                // hold the request for 0 to 3 cycles
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                rd_rdy = 1'b1;
                base   = rd_addr;
                beats  = (rd_type == icache_pkg::RD_TYPE_LINE) ? 4 : 1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int i = 0; i < beats; i++) begin
                    // gap of 0 to 2 cycles before each beat
                    repeat ($unsigned($random(seed)) % 3) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (i == beats - 1);
                    ret_data  = {2'b00, base[31:2] + 30'(i)} ^ PATTERN;
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int          WAYS    = 2;
    localparam int          LIMIT   = 6000;
    localparam logic [31:0] PATTERN = 32'h5a3c_96e1;

    logic        clk;
    logic        resetn;
    logic        valid;
    logic        uncached;
    logic [31:0] addr;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [2:0]  rd_type;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] ret_data;

    // reference model of tags plus the queue of expected answers
    logic [19:0] model_tag [WAYS][256];
    logic        model_valid [WAYS][256];
    int          model_victim;
    logic [31:0] exp_q [$];
    logic [31:0] exp_front;
    int          pending_cnt;
    logic        acc_d;
    logic        pred_hit_d;
    logic [31:0] last_addr;
    logic        last_unc;
    int          cycles;
    int          seed;

    tb_clock_gen u_clk_gen (.*);
    icache_top #(.NUM_WAYS(WAYS)) i_dut (.*);
    mem_model #(.PATTERN(PATTERN)) u_mem (.*);

    function automatic logic [31:0] memory_word(input logic [31:0] a);
        return {2'b00, a[31:2]} ^ PATTERN;
    endfunction

    function automatic logic [31:0] request_addr(input logic [31:0] a, input logic unc);
        return unc ? a : {a[31:4], 4'h0};
    endfunction

    function automatic logic [2:0] request_type(input logic unc);
        return unc ? 3'd2 : 3'd4;
    endfunction

    function automatic logic model_hit(input logic [31:0] a);
        logic h;
        h = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[w][a[11:4]] && model_tag[w][a[11:4]] == a[31:12]) begin
                h = 1'b1;
            end
        end
        return h;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic fetch(input logic [31:0] a, input logic unc);
        valid    = 1'b1;
        addr     = a;
        uncached = unc;
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic release_bus();
        valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_responses();
        while (pending_cnt != 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        logic hit_now;
        if (!resetn) begin
            exp_q.delete();
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < 256; s++) begin
                    model_valid[w][s] = 1'b0;
                end
            end
            model_victim = 0;
            acc_d        = 1'b0;
            pred_hit_d   = 1'b0;
            last_addr    = '0;
            last_unc     = 1'b0;
        end else begin
            if (data_ok && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            acc_d      = valid && addr_ok;
            pred_hit_d = 1'b0;
            if (acc_d) begin
                hit_now    = !uncached && model_hit(addr);
                pred_hit_d = hit_now;
                last_addr  = addr;
                last_unc   = uncached;
                exp_q.push_back(memory_word(addr));
                // cached miss refills the round-robin victim
                if (!uncached && !hit_now) begin
                    model_tag[model_victim][addr[11:4]]   = addr[31:12];
                    model_valid[model_victim][addr[11:4]] = 1'b1;
                    model_victim = (model_victim + 1) % WAYS;
                end
            end
        end
        pending_cnt = exp_q.size();
        exp_front   = (pending_cnt > 0) ? exp_q[0] : '0;
    end

    a_reset_values: assert property (@(posedge clk)
        $rose(resetn) |-> addr_ok && !rd_req && !data_ok)
        else report_error("addr_ok, rd_req or data_ok wrong right after reset");

    a_rsp_pending: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> pending_cnt > 0)
        else report_error("data_ok without an outstanding request");

    a_rdata: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> rdata == exp_front)
        else report_mismatch("rdata", $sampled(rdata), $sampled(exp_front));

    // a hit answers at once and keeps the fetch port open
    a_hit_latency: assert property (@(posedge clk) disable iff (!resetn)
        acc_d && pred_hit_d |-> data_ok && addr_ok)
        else report_error("predicted hit lacks data_ok or addr_ok one cycle after acceptance");

    a_miss_request: assert property (@(posedge clk) disable iff (!resetn)
        acc_d && !pred_hit_d |-> !data_ok ##1 rd_req)
        else report_error("predicted miss or uncached read did not raise rd_req");

    a_req_source: assert property (@(posedge clk) disable iff (!resetn)
        $rose(rd_req) |-> $past(acc_d && !pred_hit_d))
        else report_error("rd_req raised for a predicted hit");

    a_rd_type: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_type == request_type(last_unc))
        else report_mismatch("rd_type", 32'($sampled(rd_type)),
                             32'(request_type($sampled(last_unc))));

    a_rd_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr == request_addr(last_addr, last_unc))
        else report_mismatch("rd_addr", $sampled(rd_addr),
                             request_addr($sampled(last_addr), $sampled(last_unc)));

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("error: run did not finish within %0d cycles", LIMIT);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        seed     = 91378;
        valid    = 1'b0;
        uncached = 1'b0;
        addr     = '0;
        wait (resetn === 1'b1);
        @(negedge clk);
        // cold miss, then the whole line as back-to-back hits
        fetch(32'h0000_1008, 1'b0);
        release_bus();
        wait_responses();
        fetch(32'h0000_1000, 1'b0);
        fetch(32'h0000_1004, 1'b0);
        fetch(32'h0000_100c, 1'b0);
        fetch(32'h0000_1008, 1'b0);
        release_bus();
        wait_responses();
        // same uncached word twice
        fetch(32'h0000_2004, 1'b1);
        release_bus();
        wait_responses();
        fetch(32'h0000_2004, 1'b1);
        release_bus();
        wait_responses();
        // three tags competing for set 0x35
        for (int i = 0; i < 30; i++) begin
            fetch({20'h00011 * 20'(((i * 5) + (i / 4)) % 3 + 1), 8'h35, 2'(i), 2'b00}, 1'b0);
        end
        release_bus();
        wait_responses();
        // mixed traffic over 16 sets and 4 tags
        for (int i = 0; i < 120; i++) begin
            r = $random(seed);
            fetch({18'h0, r[1:0], 4'h0, r[5:2], r[7:6], 2'b00}, r[10:8] == 3'd0);
            if (r[11]) begin
                release_bus();
            end
        end
        release_bus();
        wait_responses();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: sim.f
src/icache_pkg.sv
src/icache_ifs.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_line_fill.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/tb_clock_gen.sv
tb/mem_model.sv
tb/icache_tb.sv
